/* Bender.yml */
package:
  name: rd_path

sources:
  - rtl/rd_path_pkg.sv
  - rtl/rd_fifo_if.sv
  - rtl/rd_latency_shifter.sv
  - rtl/rd_valid_selector.sv
  - rtl/rd_data_fifo.sv
  - rtl/rd_credit_ctrl.sv
  - rtl/rd_path_top.sv
  - target: simulation
    files:
      - sim/tb_rd_path.sv

/* rtl/rd_credit_ctrl.sv */
// read command gating and credit-based drain toward the host.
// the host must take every word it gets and keep at most 15 credits pending.
`timescale 1ns/1ps
`default_nettype none

module rd_credit_ctrl (
	input  wire                                 pll_afi_clk,
	input  wire                                 reset_n,
	input  wire                                 rd_cmd,
	output logic                                rd_cmd_ready,
	output logic                                rd_accept,
	input  wire                                 read_valid,
	input  wire                                 credit_return,
	output logic [rd_path_pkg::data_width-1:0] rdata,
	output logic                                rdata_valid,
	rd_fifo_if.drain                            d
);

	// reads accepted whose data has not reached the FIFO yet.
	logic [rd_path_pkg::fifo_cnt_width-1:0] outstanding;

	// outstanding plus stored, one bit wider so it cannot wrap.
	logic [rd_path_pkg::fifo_cnt_width:0] reserved;

	// credits the host has granted and we have not used.
	logic [rd_path_pkg::host_credit_width-1:0] credit_cnt;

	// ********************
	// command gating
	// ********************

	assign reserved = {1'b0, outstanding} + {1'b0, d.used};

	// accept only while every read in flight still has an entry reserved.
	assign rd_cmd_ready = (reserved < (rd_path_pkg::fifo_cnt_width + 1)'(rd_path_pkg::fifo_depth));

	assign rd_accept = rd_cmd && rd_cmd_ready;

	// up on accept, down when the data is written to the FIFO.
	always_ff @(posedge pll_afi_clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			outstanding <= '0;
		end
		else
		begin
			case ({rd_accept, read_valid})
				2'b10:   outstanding <= outstanding + 1'b1;
				2'b01:   outstanding <= outstanding - 1'b1;
				default: outstanding <= outstanding;
			endcase
		end
	end

	// ********************
	// host credits
	// ********************

	// pop whenever a word is stored and a credit remains.
	assign d.pop = !d.empty && (credit_cnt != '0);

	// a returned credit and a pop in one cycle cancel out.
	always_ff @(posedge pll_afi_clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			// the host starts with no credits.
			credit_cnt <= '0;
		end
		else
		begin
			case ({credit_return, d.pop})
				2'b10:   credit_cnt <= credit_cnt + 1'b1;
				2'b01:   credit_cnt <= credit_cnt - 1'b1;
				default: credit_cnt <= credit_cnt;
			endcase
		end
	end

	// ********************
	// output drive
	// ********************

	// popped word, one cycle after the pop.
	always_ff @(posedge pll_afi_clk)
	begin
		if (d.pop)
			rdata <= d.rdata;
	end

	always_ff @(posedge pll_afi_clk or negedge reset_n)
	begin
		if (!reset_n)
			rdata_valid <= 1'b0;
		else
			rdata_valid <= d.pop;
	end

endmodule

`default_nettype wire

/* rtl/rd_data_fifo.sv */
// read data buffer, written on read_valid and drained through the fifo modport.
// command gating keeps a free entry for every read in flight, so it never overflows.
`timescale 1ns/1ps
`default_nettype none

module rd_data_fifo (
	input  wire                                pll_afi_clk,
	input  wire                                reset_n,
	input  wire                                read_valid,
	input  wire [rd_path_pkg::data_width-1:0] phy_rdata,
	rd_fifo_if.fifo                            f
);

	// ********************
	// storage
	// ********************

	// entry array.
	logic [rd_path_pkg::data_width-1:0] mem [rd_path_pkg::fifo_depth];

	// pointers are one bit narrower than the count and wrap at fifo_depth.
	logic [rd_path_pkg::fifo_cnt_width-2:0] wr_ptr;
	logic [rd_path_pkg::fifo_cnt_width-2:0] rd_ptr;

	// fill count.
	logic [rd_path_pkg::fifo_cnt_width-1:0] used_cnt;

	// a pop that actually removes an entry.
	logic do_pop;

	assign do_pop = f.pop && (used_cnt != '0);

	// capture the PHY word at the end of its valid cycle.
	always_ff @(posedge pll_afi_clk)
	begin
		if (read_valid)
			mem[wr_ptr] <= phy_rdata;
	end

	// ********************
	// pointers and count
	// ********************

	always_ff @(posedge pll_afi_clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else
		begin
			if (read_valid)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	// write and pop in one cycle leave the count unchanged.
	always_ff @(posedge pll_afi_clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			used_cnt <= '0;
		end
		else
		begin
			case ({read_valid, do_pop})
				2'b10:   used_cnt <= used_cnt + 1'b1;
				2'b01:   used_cnt <= used_cnt - 1'b1;
				default: used_cnt <= used_cnt;
			endcase
		end
	end

	// ********************
	// drain side view
	// ********************

	// head entry is shown in the cycle of the pop.
	assign f.rdata = mem[rd_ptr];

	// empty straight from the count.
	assign f.empty = (used_cnt == '0);

	// fill count for command gating.
	assign f.used = used_cnt;

endmodule

`default_nettype wire

/* rtl/rd_fifo_if.sv */
// link between the read FIFO and the drain logic.
// pop only while empty is low; the head word leaves on the edge that samples pop.
`timescale 1ns/1ps
`default_nettype none

interface rd_fifo_if;

	// drain side asks for the head word.
	logic pop;

	// head entry, valid in the same cycle as pop.
	logic [rd_path_pkg::data_width-1:0] rdata;

	// no entry stored.
	logic empty;

	// fill count, 0 to fifo_depth.
	logic [rd_path_pkg::fifo_cnt_width-1:0] used;

	// storage side.
	modport fifo (
		input  pop,
		output rdata,
		output empty,
		output used
	);

	// drain and credit side.
	modport drain (
		output pop,
		input  rdata,
		input  empty,
		input  used
	);

endinterface

`default_nettype wire

/* rtl/rd_latency_shifter.sv */
// history of accepted read commands, one bit per cycle since issue.
// tap k is high k+1 cycles after the edge that accepted the read.
`timescale 1ns/1ps
`default_nettype none

module rd_latency_shifter (
	input  wire                                  pll_afi_clk,
	input  wire                                  reset_n,
	input  wire                                  rd_accept,
	output logic [rd_path_pkg::latency_num-1:0] latency_shifter
);

	// ********************
	// command history
	// ********************

	// bit 0 holds the read accepted on the previous edge.
	// older reads move up one tap per cycle.
	// a read that passes the last tap is dropped.
	always_ff @(posedge pll_afi_clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			// no reads in flight after reset.
			latency_shifter <= '0;
		end
		else
		begin
			latency_shifter <= {latency_shifter[rd_path_pkg::latency_num-2:0], rd_accept};
		end
	end

endmodule

`default_nettype wire

/* rtl/rd_path_pkg.sv */
// sizes for the read-valid datapath; fifo_cnt_width must hold 0 to fifo_depth.
// fifo_depth is a power of two so the FIFO pointers wrap on their own.
`default_nettype none

package rd_path_pkg;

	// ********************
	// latency
	// ********************

	// width of the programmable read latency, latencies 0 to 7.
	localparam int max_latency_count_width = 3;

	// one shifter tap and one decode output per possible latency.
	localparam int latency_num = 2 ** max_latency_count_width;

	// ********************
	// data and buffering
	// ********************

	// PHY and host read data width.
	localparam int data_width = 32;

	// read FIFO entries.
	localparam int fifo_depth = 8;

	// fill count and outstanding count, one bit wider than the pointers.
	localparam int fifo_cnt_width = 4;

	// host credit counter, the host keeps at most 15 credits pending.
	localparam int host_credit_width = 4;

endpackage

`default_nettype wire

/* rtl/rd_path_top.sv */
// read-valid datapath top; latency_count changes only while no reads are outstanding.
// command to rdata_valid takes latency_count+4 cycles at best, more when credits run out.
`timescale 1ns/1ps
`default_nettype none

module rd_path_top (
	input  wire                                              pll_afi_clk,
	input  wire                                              reset_n,
	input  wire                                              rd_cmd,
	input  wire [rd_path_pkg::max_latency_count_width-1:0]  latency_count,
	input  wire [rd_path_pkg::data_width-1:0]               phy_rdata,
	input  wire                                              credit_return,
	output logic                                             rd_cmd_ready,
	output logic [rd_path_pkg::data_width-1:0]              rdata,
	output logic                                             rdata_valid
);

	// ********************
	// internal links
	// ********************

	// command accepted this cycle.
	logic rd_accept;

	// per-cycle history of accepted reads.
	logic [rd_path_pkg::latency_num-1:0] latency_shifter;

	// PHY data valid this cycle.
	logic read_valid;

	// FIFO to drain link.
	rd_fifo_if fifo_bus ();

	// ********************
	// blocks
	// ********************

	// shift register of issued reads.
	rd_latency_shifter i_rd_latency_shifter (
		.pll_afi_clk     (pll_afi_clk),
		.reset_n         (reset_n),
		.rd_accept       (rd_accept),
		.latency_shifter (latency_shifter)
	);

	// picks the tap for the set latency.
	rd_valid_selector i_rd_valid_selector (
		.pll_afi_clk     (pll_afi_clk),
		.reset_n         (reset_n),
		.latency_shifter (latency_shifter),
		.latency_count   (latency_count),
		.read_valid      (read_valid)
	);

	// buffers PHY words until the host has credit.
	rd_data_fifo i_rd_data_fifo (
		.pll_afi_clk (pll_afi_clk),
		.reset_n     (reset_n),
		.read_valid  (read_valid),
		.phy_rdata   (phy_rdata),
		.f           (fifo_bus.fifo)
	);

	// gates commands and drains the FIFO on host credits.
	rd_credit_ctrl i_rd_credit_ctrl (
		.pll_afi_clk   (pll_afi_clk),
		.reset_n       (reset_n),
		.rd_cmd        (rd_cmd),
		.rd_cmd_ready  (rd_cmd_ready),
		.rd_accept     (rd_accept),
		.read_valid    (read_valid),
		.credit_return (credit_return),
		.rdata         (rdata),
		.rdata_valid   (rdata_valid),
		.d             (fifo_bus.drain)
	);

endmodule

`default_nettype wire

/* rtl/rd_valid_selector.sv */
// flags the cycle in which PHY read data is valid for the set latency.
// latency_count may change only while no reads are outstanding.
`timescale 1ns/1ps
`default_nettype none

module rd_valid_selector (
	input  wire                                              pll_afi_clk,
	input  wire                                              reset_n,
	input  wire [rd_path_pkg::latency_num-1:0]              latency_shifter,
	input  wire [rd_path_pkg::max_latency_count_width-1:0]  latency_count,
	output logic                                             read_valid
);

	// one-hot decode of the latency count.
	logic [rd_path_pkg::latency_num-1:0] selector;

	// registered decode, keeps the decoder off the tap path.
	logic [rd_path_pkg::latency_num-1:0] selector_reg;

	// the one tap that matches the latency.
	logic [rd_path_pkg::latency_num-1:0] valid_select;

	// ********************
	// latency decode
	// ********************

	always_comb
	begin
		selector = '0;
		selector[latency_count] = 1'b1;
	end

	always_ff @(posedge pll_afi_clk or negedge reset_n)
	begin
		if (!reset_n)
			selector_reg <= '0;
		else
			selector_reg <= selector;
	end

	// ********************
	// tap select
	// ********************

	assign valid_select = selector_reg & latency_shifter;

	// tap L is high in cycle t+1+L, so read_valid is high in cycle t+2+L.
	always_ff @(posedge pll_afi_clk or negedge reset_n)
	begin
		if (!reset_n)
			read_valid <= 1'b0;
		else
			read_valid <= |valid_select;
	end

endmodule

`default_nettype wire

/* sim/tb_rd_path.sv */
// testbench for rd_path_top; a PHY delay line returns ref_word(n) for read n.
// latency changes only while no reads are in flight; the host never holds more than 14 credits.
`timescale 1ns/1ps
`default_nettype none

module tb_rd_path;

	// ********************
	// sizes and limits
	// ********************

	localparam int burst_len = 6;
	localparam int rand_rounds = 6;
	localparam int rand_cycles = 40;
	localparam int max_gap = 6;
	localparam int max_reads = rd_path_pkg::latency_num * burst_len + rd_path_pkg::fifo_depth
		+ rand_rounds * rand_cycles;
	// each read takes at most 7+4 cycles, plus the credit gaps and a margin.
	localparam int timeout_cycles = max_reads * (7 + 4)
		+ rd_path_pkg::fifo_depth * (max_gap + 2) + 600;

	logic                                            pll_afi_clk = 1'b0;
	logic                                            reset_n;
	logic                                            rd_cmd;
	logic [rd_path_pkg::max_latency_count_width-1:0] latency_count;
	logic [rd_path_pkg::data_width-1:0]              phy_rdata;
	logic                                            credit_return;
	logic                                            rd_cmd_ready;
	logic [rd_path_pkg::data_width-1:0]              rdata;
	logic                                            rdata_valid;

	// accepted reads, fired PHY words, words seen at the host, credits granted.
	int unsigned issued;
	int unsigned fired;
	int unsigned words_rcvd;
	int unsigned credits_given;
	int unsigned cycle_cnt;
	int unsigned start_issued;
	int          gap;
	logic        cred;

	// accepted reads still waiting for their PHY word.
	logic [rd_path_pkg::latency_num:0] phy_pipe;

	rd_path_top i_rd_path_top (
		.pll_afi_clk   (pll_afi_clk),
		.reset_n       (reset_n),
		.rd_cmd        (rd_cmd),
		.latency_count (latency_count),
		.phy_rdata     (phy_rdata),
		.credit_return (credit_return),
		.rd_cmd_ready  (rd_cmd_ready),
		.rdata         (rdata),
		.rdata_valid   (rdata_valid)
	);

	always #2 pll_afi_clk = ~pll_afi_clk;

	// ********************
	// reference and checks
	// ********************

	// expected word for read number n, a multiply and xor mix.
	function automatic logic [31:0] ref_word(input logic [31:0] n);
		logic [31:0] x;
		x = n * 32'h9e37_79b1;
		x = x ^ (x >> 15);
		x = x ^ {n[15:0], 16'h5a3c};
		return x;
	endfunction

	// ends the run on the first failure.
	task automatic abort_run();
		$display("TEST FAILED");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("** Error at %0t ns: %s got %h expected %h", $time, what, got, exp);
			abort_run();
		end
	endtask

	// host side, one expected word per rdata_valid, never more words than credits.
	always @(negedge pll_afi_clk)
	begin
		if (reset_n && rdata_valid)
		begin
			check_value("rdata", rdata, ref_word(words_rcvd));
			check_value("word within credits", 32'(words_rcvd + 1 <= credits_given), 32'd1);
			words_rcvd <= words_rcvd + 1;
		end
	end

	always @(posedge pll_afi_clk)
	begin
		cycle_cnt++;
		if (cycle_cnt > timeout_cycles)
		begin
			$display("timeout: the run did not finish within %0d cycles", timeout_cycles);
			abort_run();
		end
	end

	// ********************
	// PHY model
	// ********************

	// delay line of length latency_count+2 on accepted reads.
	// a read drops out after the tap that drives its word.
	always @(posedge pll_afi_clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			phy_pipe <= '0;
			issued <= 0;
		end
		else
		begin
			for (int k = rd_path_pkg::latency_num; k > 0; k--)
				phy_pipe[k] <= phy_pipe[k-1] && (k <= int'(latency_count) + 1);
			phy_pipe[0] <= rd_cmd && rd_cmd_ready;
			if (rd_cmd && rd_cmd_ready)
				issued <= issued + 1;
		end
	end

	// the word is held for the whole read_valid cycle, X otherwise.
	always @(negedge pll_afi_clk)
	begin
		if (phy_pipe[latency_count + 1])
		begin
			phy_rdata = ref_word(fired);
			fired++;
		end
		else
		begin
			phy_rdata = 'x;
		end
	end

	// ********************
	// stimulus tasks
	// ********************

	// keeps rd_cmd high until count more reads are accepted.
	task automatic issue_reads(input int count);
		int unsigned target;
		target = issued + count;
		@(negedge pll_afi_clk);
		while (issued < target)
		begin
			rd_cmd = 1'b1;
			@(negedge pll_afi_clk);
		end
		rd_cmd = 1'b0;
	endtask

	task automatic give_credits(input int count);
		repeat (count)
		begin
			@(negedge pll_afi_clk);
			credit_return = 1'b1;
			credits_given++;
		end
		@(negedge pll_afi_clk);
		credit_return = 1'b0;
	endtask

	task automatic wait_words(input int unsigned target);
		while (words_rcvd < target)
			@(negedge pll_afi_clk);
	endtask

	// ********************
	// test sequence
	// ********************

	initial
	begin
		void'($urandom(28));
		reset_n = 1'b0;
		rd_cmd = 1'b0;
		latency_count = '0;
		phy_rdata = '0;
		credit_return = 1'b0;
		issued = 0;
		fired = 0;
		words_rcvd = 0;
		credits_given = 0;
		cycle_cnt = 0;
		repeat (8) @(posedge pll_afi_clk);
		@(negedge pll_afi_clk);
		reset_n = 1'b1;

		// idle after reset.
		repeat (3)
		begin
			@(negedge pll_afi_clk);
			check_value("rdata_valid after reset", 32'(rdata_valid), 32'd0);
			check_value("rd_cmd_ready after reset", 32'(rd_cmd_ready), 32'd1);
		end

		// one burst per latency, credits granted up front.
		for (int lat = 0; lat < rd_path_pkg::latency_num; lat++)
		begin
			@(negedge pll_afi_clk);
			latency_count = lat[rd_path_pkg::max_latency_count_width-1:0];
			give_credits(burst_len);
			issue_reads(burst_len);
			wait_words(issued);
		end

		// no credits, so the FIFO fills and command issue stops.
		start_issued = issued;
		@(negedge pll_afi_clk);
		rd_cmd = 1'b1;
		repeat (rd_path_pkg::fifo_depth + 16) @(negedge pll_afi_clk);
		rd_cmd = 1'b0;
		check_value("reads accepted without credit", issued - start_issued,
			rd_path_pkg::fifo_depth);
		check_value("rd_cmd_ready with full FIFO", 32'(rd_cmd_ready), 32'd0);
		check_value("words without credit", words_rcvd, credits_given);

		// single credits at random gaps, one word each.
		repeat (rd_path_pkg::fifo_depth)
		begin
			give_credits(1);
			wait_words(credits_given);
			gap = $urandom_range(max_gap, 1);
			repeat (gap) @(negedge pll_afi_clk);
			check_value("words per credit", words_rcvd, credits_given);
		end

		// random commands and credits at random latencies.
		repeat (rand_rounds)
		begin
			@(negedge pll_afi_clk);
			latency_count = (rd_path_pkg::max_latency_count_width)'(
				$urandom_range(rd_path_pkg::latency_num - 1, 0));
			repeat (rand_cycles)
			begin
				@(negedge pll_afi_clk);
				rd_cmd = 1'($urandom_range(1, 0));
				cred = $urandom_range(1, 0) && (credits_given - words_rcvd < 14);
				credit_return = cred;
				if (cred)
					credits_given++;
			end
			@(negedge pll_afi_clk);
			rd_cmd = 1'b0;
			credit_return = 1'b0;
			// drain with just enough credits for every read issued.
			while (words_rcvd < issued)
			begin
				cred = (credits_given < issued) && (credits_given - words_rcvd < 14);
				credit_return = cred;
				if (cred)
					credits_given++;
				@(negedge pll_afi_clk);
			end
			credit_return = 1'b0;
		end

		repeat (4) @(negedge pll_afi_clk);
		check_value("total words", words_rcvd, issued);
		check_value("rd_cmd_ready at the end", 32'(rd_cmd_ready), 32'd1);

		$display("TEST PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* tb.f */
rtl/rd_path_pkg.sv
rtl/rd_fifo_if.sv
rtl/rd_latency_shifter.sv
rtl/rd_valid_selector.sv
rtl/rd_data_fifo.sv
rtl/rd_credit_ctrl.sv
rtl/rd_path_top.sv
sim/tb_rd_path.sv
